/* sim.f */
turfio_pkg.sv
uart_retime.sv
crate_uart_router.sv
tio_id_ctrl.sv
turfio_hsk_top.sv
tb_turfio_hsk.sv

/* tb_turfio_hsk.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_turfio_hsk;
    import turfio_pkg::*;

    localparam int          BAUD      = 16;
    localparam int          SAMPLE    = 12;
    localparam int          CREDITS   = 2;
    localparam logic [3:0]  V_MAJOR   = 4'd1;
    localparam logic [3:0]  V_MINOR   = 4'd3;
    localparam logic [7:0]  V_REV     = 8'h2A;
    localparam logic [15:0] FW_DATE   = 16'h0A17;
    localparam int          WAIT_MAX  = 40 * BAUD;
    localparam int          SLOW_RISE = 5;
    // Line selectors for the serial helpers
    localparam int          SEL_DBG   = 0;
    localparam int          SEL_TURF  = 1;
    localparam int          SEL_SURF  = 2;
    localparam int          SEL_HSK   = 3;

    logic        init_clk;
    logic        rst_n_i;
    logic        dbg_rx_i;
    logic        turf_rx_i;
    logic        tctrl_b_i;
    logic        surf_tx_i;
    logic        hsk_uart_rx_i;
    logic        dbg_tx_o;
    logic        turf_tx_o;
    logic        surf_rx_o;
    logic        hsk_uart_tx_o;
    logic [1:0]  conf_i;
    logic        enable_crate_o;
    logic        enable_3v3_o;
    logic        calsel_o;
    logic        calpwdn_o;
    logic        req_valid_i;
    reg_op_e     req_op_i;
    reg_sel_e    req_addr_i;
    logic [31:0] req_wdata_i;
    logic        credit_o;
    logic        resp_valid_o;
    logic [31:0] resp_rdata_o;

    int                    mismatches;
    int                    errors;
    int                    outstanding;
    logic [31:0]           rng_state;
    logic [31:0]           r;
    logic [7:0]            byte_v;
    logic [CTRL_WIDTH-1:0] ctrl_shadow;
    logic [7:0]            exp_count;
    logic [31:0]           exp_q[$];
    string                 name_q[$];
    logic [31:0]           exp_word;
    string                 resp_name;

    turfio_hsk_top #(
        .BAUD_PERIOD  (BAUD),
        .SAMPLE_POINT (SAMPLE),
        .REQ_CREDITS  (CREDITS),
        .VER_MAJOR    (V_MAJOR),
        .VER_MINOR    (V_MINOR),
        .VER_REV      (V_REV),
        .FIRMWARE_DATE(FW_DATE)
    ) dut0 (
        .init_clk      (init_clk),
        .rst_n_i       (rst_n_i),
        .dbg_rx_i      (dbg_rx_i),
        .turf_rx_i     (turf_rx_i),
        .tctrl_b_i     (tctrl_b_i),
        .surf_tx_i     (surf_tx_i),
        .hsk_uart_rx_i (hsk_uart_rx_i),
        .dbg_tx_o      (dbg_tx_o),
        .turf_tx_o     (turf_tx_o),
        .surf_rx_o     (surf_rx_o),
        .hsk_uart_tx_o (hsk_uart_tx_o),
        .conf_i        (conf_i),
        .enable_crate_o(enable_crate_o),
        .enable_3v3_o  (enable_3v3_o),
        .calsel_o      (calsel_o),
        .calpwdn_o     (calpwdn_o),
        .req_valid_i   (req_valid_i),
        .req_op_i      (req_op_i),
        .req_addr_i    (req_addr_i),
        .req_wdata_i   (req_wdata_i),
        .credit_o      (credit_o),
        .resp_valid_o  (resp_valid_o),
        .resp_rdata_o  (resp_rdata_o)
    );

    // 100 MHz
    always #5 init_clk = ~init_clk;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] rand_next();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // Expected read word, from the shadow state at issue time
    function automatic logic [31:0] reg_model(input reg_op_e op, input logic [3:0] addr);
        logic [31:0] w;
        w = 32'd0;
        if (op == REG_READ) begin
            case (addr)
                REG_IDENT:   w = TURFIO_IDENT;
                REG_DATEVER: w = {FW_DATE, V_MAJOR, V_MINOR, V_REV};
                REG_CONTROL: w[CTRL_WIDTH-1:0] = ctrl_shadow;
                REG_STATUS: begin
                    w[STAT_RXCOUNT_LSB +: 8] = exp_count;
                    w[STAT_CONF_LSB +: 2]    = conf_i;
                    w[STAT_TCTRL_B]          = tctrl_b_i;
                end
                default:     w = 32'd0;
            endcase
        end
        return w;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Checks done: %0d mismatches, %0d other errors", mismatches, errors);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic drive_line(input int sel, input logic v);
        case (sel)
            SEL_DBG:  dbg_rx_i <= v;
            SEL_TURF: turf_rx_i <= v;
            SEL_SURF: surf_tx_i <= v;
            default:  hsk_uart_rx_i <= v;
        endcase
    endtask

    function automatic logic tap_out(input int sel);
        case (sel)
            SEL_DBG:  return dbg_tx_o;
            SEL_TURF: return turf_tx_o;
            SEL_SURF: return surf_rx_o;
            default:  return hsk_uart_tx_o;
        endcase
    endfunction

    // 8N1 frame, LSB first
    task automatic send_frame(input int sel, input logic [7:0] data);
        logic [9:0] frame;
        logic       prev;
        logic       slow;
        frame = {1'b1, data, 1'b0};
        prev  = 1'b1;
        for (int i = 0; i < UART_FRAME_BITS; i++) begin
            // Open-drain crate reply lags on the way up
            slow = (sel == SEL_SURF) && frame[i] && !prev;
            for (int c = 0; c < BAUD; c++) begin
                @(posedge init_clk);
                if (c == (slow ? SLOW_RISE : 0)) begin
                    drive_line(sel, frame[i]);
                end
            end
            prev = frame[i];
        end
    endtask

    // Status 0 no start edge, 1 good frame, 2 framing error
    task automatic recv_frame(input int sel, output logic [7:0] data, output int status);
        logic prev;
        logic cur;
        logic framed;
        int   waited;
        data   = 8'h00;
        status = 0;
        prev   = 1'b1;
        cur    = 1'b1;
        waited = 0;
        while (!(prev && !cur) && waited < WAIT_MAX) begin
            @(negedge init_clk);
            prev = cur;
            cur  = tap_out(sel);
            waited++;
        end
        if (prev && !cur) begin
            // Middle of the start bit
            repeat (BAUD / 2 - 1) @(negedge init_clk);
            framed = !tap_out(sel);
            for (int i = 0; i < UART_DATA_BITS; i++) begin
                repeat (BAUD) @(negedge init_clk);
                data[i] = tap_out(sel);
            end
            repeat (BAUD) @(negedge init_clk);
            framed = framed && tap_out(sel);
            status = framed ? 1 : 2;
        end
    endtask

    task automatic expect_frame(input int sel, input logic [7:0] exp, input string name);
        logic [7:0] got;
        int         st;
        recv_frame(sel, got, st);
        if (st == 0) begin
            abort_run({"Timed out waiting for a start bit in ", name});
        end else if (st == 2) begin
            errors++;
            $display("Bad start or stop bit in %s", name);
        end else if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s expected %h actual %h", name, exp, got);
        end
    endtask

    task automatic watch_high(input int sel, input int cycles, input string name);
        logic seen_low;
        seen_low = 1'b0;
        for (int c = 0; c < cycles; c++) begin
            @(negedge init_clk);
            if (tap_out(sel) !== 1'b1) begin
                seen_low = 1'b1;
            end
        end
        if (seen_low) begin
            mismatches++;
            $display("MISMATCH %s expected 1 actual 0", name);
        end
    endtask

    // Spends a credit, waits for one when none is held
    task automatic send_req(input reg_op_e op, input logic [3:0] addr,
                            input logic [31:0] wdata, input string name);
        int waited;
        waited = 0;
        while (outstanding >= CREDITS && waited < WAIT_MAX) begin
            @(posedge init_clk);
            req_valid_i <= 1'b0;
            waited++;
        end
        if (outstanding >= CREDITS) begin
            abort_run({"No credit came back while issuing ", name});
        end else begin
            @(posedge init_clk);
            req_valid_i <= 1'b1;
            req_op_i    <= op;
            req_addr_i  <= reg_sel_e'(addr);
            req_wdata_i <= wdata;
            exp_q.push_back(reg_model(op, addr));
            name_q.push_back(name);
            if (op == REG_WRITE && addr == REG_CONTROL) begin
                ctrl_shadow = wdata[CTRL_WIDTH-1:0];
            end
            outstanding++;
        end
    endtask

    task automatic drain_reqs();
        int waited;
        waited = 0;
        @(posedge init_clk);
        req_valid_i <= 1'b0;
        while (outstanding != 0 && waited < WAIT_MAX) begin
            @(negedge init_clk);
            waited++;
        end
        if (outstanding != 0) begin
            abort_run("Responses stopped before every request was answered");
        end
    endtask

    task automatic set_ctrl(input logic [31:0] value);
        send_req(REG_WRITE, REG_CONTROL, value, "mode_write");
        drain_reqs();
    endtask

    //////////////////////////////////////////////////
    // Response and credit checker
    //////////////////////////////////////////////////

    always @(negedge init_clk) begin
        if (rst_n_i) begin
            if (credit_o !== resp_valid_o) begin
                errors++;
                $display("Credit pulse and response pulse out of step");
            end
            if (resp_valid_o) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Response arrived with no request outstanding");
                end else begin
                    exp_word  = exp_q.pop_front();
                    resp_name = name_q.pop_front();
                    if (resp_rdata_o !== exp_word) begin
                        mismatches++;
                        $display("MISMATCH %s expected %h actual %h",
                                 resp_name, exp_word, resp_rdata_o);
                    end
                end
            end
            if (credit_o) begin
                if (outstanding == 0) begin
                    errors++;
                    $display("Credit returned beyond those spent");
                end else begin
                    outstanding--;
                end
            end
            // Requests still waiting for their response
            if (exp_q.size() > CREDITS) begin
                errors++;
                $display("More requests outstanding than credits exist");
            end
        end
    end

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    initial begin
        init_clk      = 1'b0;
        rst_n_i       = 1'b0;
        dbg_rx_i      = 1'b1;
        turf_rx_i     = 1'b1;
        tctrl_b_i     = 1'b0;
        surf_tx_i     = 1'b1;
        hsk_uart_rx_i = 1'b1;
        conf_i        = 2'b00;
        req_valid_i   = 1'b0;
        req_op_i      = REG_READ;
        req_addr_i    = REG_IDENT;
        req_wdata_i   = 32'd0;
        rng_state     = 32'd10243;
        mismatches    = 0;
        errors        = 0;
        outstanding   = 0;
        ctrl_shadow   = '0;
        exp_count     = 8'd0;
        repeat (4) @(posedge init_clk);
        rst_n_i <= 1'b1;
        r = rand_next();
        conf_i <= r[1:0];
        @(posedge init_clk);

        // Reset state
        @(negedge init_clk);
        if ({enable_crate_o, enable_3v3_o, calsel_o, calpwdn_o} !== 4'b0000) begin
            mismatches++;
            $display("MISMATCH reset_ctrl expected 0 actual %b",
                     {enable_crate_o, enable_3v3_o, calsel_o, calpwdn_o});
        end
        if ({dbg_tx_o, surf_rx_o} !== 2'b11) begin
            mismatches++;
            $display("MISMATCH reset_lines expected 11 actual %b", {dbg_tx_o, surf_rx_o});
        end
        send_req(REG_READ, REG_IDENT, 32'd0, "reset_ident");
        send_req(REG_READ, REG_DATEVER, 32'd0, "reset_datever");
        drain_reqs();

        // Random traffic, bursts whenever both credits are free
        for (int i = 0; i < 24; i++) begin
            r = rand_next();
            send_req(reg_op_e'(r[0]), r[7:4], rand_next(), "credit_flow");
            if (r[8]) begin
                send_req(REG_READ, r[15:12], 32'd0, "credit_burst");
            end
            if (r[9]) begin
                @(posedge init_clk);
                req_valid_i <= 1'b0;
                repeat (r[11:10]) @(posedge init_clk);
            end
        end
        drain_reqs();

        // Control register and its pins
        for (int i = 0; i < 6; i++) begin
            send_req(REG_WRITE, REG_CONTROL, rand_next(), "ctrl_write");
            send_req(REG_READ, REG_CONTROL, 32'd0, "ctrl_readback");
            drain_reqs();
            @(negedge init_clk);
            if ({calpwdn_o, calsel_o, enable_3v3_o, enable_crate_o} !==
                {ctrl_shadow[CTRL_CALPWDN], ctrl_shadow[CTRL_CALSEL],
                 ctrl_shadow[CTRL_EN_3V3], ctrl_shadow[CTRL_ENABLE_CRATE]}) begin
                mismatches++;
                $display("MISMATCH ctrl_pins expected %b actual %b", ctrl_shadow[5:2],
                         {calpwdn_o, calsel_o, enable_3v3_o, enable_crate_o});
            end
        end

        // Remote mode, TURF drives the crate
        set_ctrl(32'd1 << CTRL_CRATE_EN);
        r = rand_next();
        byte_v = r[7:0];
        fork
            send_frame(SEL_TURF, byte_v);
            expect_frame(SEL_SURF, byte_v, "remote_fwd_surf");
            expect_frame(SEL_HSK, byte_v, "remote_fwd_hsk");
        join
        r = rand_next();
        byte_v = r[7:0];
        fork
            send_frame(SEL_SURF, byte_v);
            expect_frame(SEL_TURF, byte_v, "remote_reply");
        join
        exp_count++;
        repeat (2 * BAUD) @(posedge init_clk);
        send_req(REG_READ, REG_STATUS, 32'd0, "remote_status");
        drain_reqs();
        // TURF pins in I2C use, crate line held idle
        @(posedge init_clk);
        tctrl_b_i <= 1'b1;
        fork
            send_frame(SEL_TURF, 8'h55);
            watch_high(SEL_SURF, UART_FRAME_BITS * BAUD + 2, "tctrl_block");
        join
        send_req(REG_READ, REG_STATUS, 32'd0, "tctrl_status");
        drain_reqs();
        @(posedge init_clk);
        tctrl_b_i <= 1'b0;

        // Local debug mode
        set_ctrl((32'd1 << CTRL_HSK_LOCAL) | (32'd1 << CTRL_CRATE_EN));
        r = rand_next();
        byte_v = r[7:0];
        fork
            send_frame(SEL_DBG, byte_v);
            expect_frame(SEL_SURF, byte_v, "local_fwd");
        join
        r = rand_next();
        byte_v = r[7:0];
        fork
            send_frame(SEL_SURF, byte_v);
            expect_frame(SEL_DBG, byte_v, "local_surf_reply");
            watch_high(SEL_TURF, 12 * BAUD, "local_turf_idle");
        join
        exp_count++;
        r = rand_next();
        byte_v = r[7:0];
        fork
            send_frame(SEL_HSK, byte_v);
            expect_frame(SEL_DBG, byte_v, "local_hsk_reply");
            watch_high(SEL_TURF, 12 * BAUD, "local_turf_idle");
        join
        exp_count++;
        // Crate gated off, its reply never reaches the bus
        set_ctrl(32'd1 << CTRL_HSK_LOCAL);
        r = rand_next();
        byte_v = r[7:0];
        fork
            send_frame(SEL_SURF, byte_v);
            watch_high(SEL_DBG, 12 * BAUD, "crate_disabled");
        join
        repeat (2 * BAUD) @(posedge init_clk);
        send_req(REG_READ, REG_STATUS, 32'd0, "local_status");
        drain_reqs();

        $display("Checks done: %0d mismatches, %0d other errors", mismatches, errors);
        if (mismatches == 0 && errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* turfio_hsk_top.sv */
`timescale 1ns/1ps
`default_nettype none

module turfio_hsk_top #(
    parameter int          BAUD_PERIOD   = 160,
    parameter int          SAMPLE_POINT  = 120,
    parameter int          REQ_CREDITS   = 2,
    parameter logic [3:0]  VER_MAJOR     = 4'd0,
    parameter logic [3:0]  VER_MINOR     = 4'd6,
    parameter logic [7:0]  VER_REV       = 8'd0,
    parameter logic [15:0] FIRMWARE_DATE = 16'h0000
) (
    input  wire                       init_clk,
    input  wire                       rst_n_i,
    // Serial lines, all idle high
    input  wire                       dbg_rx_i,
    input  wire                       turf_rx_i,
    input  wire                       tctrl_b_i,
    input  wire                       surf_tx_i,
    input  wire                       hsk_uart_rx_i,
    output logic                      dbg_tx_o,
    output logic                      turf_tx_o,
    output logic                      surf_rx_o,
    output logic                      hsk_uart_tx_o,
    // Crate controls
    input  wire [1:0]                 conf_i,
    output logic                      enable_crate_o,
    output logic                      enable_3v3_o,
    output logic                      calsel_o,
    output logic                      calpwdn_o,
    // Register channel
    input  wire                       req_valid_i,
    input  wire turfio_pkg::reg_op_e  req_op_i,
    input  wire turfio_pkg::reg_sel_e req_addr_i,
    input  wire [31:0]                req_wdata_i,
    output logic                      credit_o,
    output logic                      resp_valid_o,
    output logic [31:0]               resp_rdata_o
);

    logic       surf_retimed;
    logic [7:0] rx_count;
    logic       hsk_local;
    logic       crate_en;

    // Open-drain crate reply, late sample for the slow rise
    uart_retime #(
        .BAUD_PERIOD (BAUD_PERIOD),
        .SAMPLE_POINT(SAMPLE_POINT)
    ) u_retime (
        .init_clk (init_clk),
        .rst_n_i  (rst_n_i),
        .line_i   (surf_tx_i),
        .retimed_o(surf_retimed)
    );

    crate_uart_router #(
        .BAUD_PERIOD(BAUD_PERIOD)
    ) u_router (
        .init_clk      (init_clk),
        .rst_n_i       (rst_n_i),
        .hsk_local_i   (hsk_local),
        .crate_en_i    (crate_en),
        .dbg_rx_i      (dbg_rx_i),
        .turf_rx_i     (turf_rx_i),
        .tctrl_b_i     (tctrl_b_i),
        .surf_retimed_i(surf_retimed),
        .hsk_uart_rx_i (hsk_uart_rx_i),
        .dbg_tx_o      (dbg_tx_o),
        .turf_tx_o     (turf_tx_o),
        .surf_rx_o     (surf_rx_o),
        .hsk_uart_tx_o (hsk_uart_tx_o),
        .rx_count_o    (rx_count)
    );

    // ID, version, control and status
    tio_id_ctrl #(
        .REQ_CREDITS  (REQ_CREDITS),
        .VER_MAJOR    (VER_MAJOR),
        .VER_MINOR    (VER_MINOR),
        .VER_REV      (VER_REV),
        .FIRMWARE_DATE(FIRMWARE_DATE)
    ) u_id_ctrl (
        .init_clk      (init_clk),
        .rst_n_i       (rst_n_i),
        .req_valid_i   (req_valid_i),
        .req_op_i      (req_op_i),
        .req_addr_i    (req_addr_i),
        .req_wdata_i   (req_wdata_i),
        .credit_o      (credit_o),
        .resp_valid_o  (resp_valid_o),
        .resp_rdata_o  (resp_rdata_o),
        .rx_count_i    (rx_count),
        .conf_i        (conf_i),
        .tctrl_b_i     (tctrl_b_i),
        .hsk_local_o   (hsk_local),
        .crate_en_o    (crate_en),
        .enable_crate_o(enable_crate_o),
        .enable_3v3_o  (enable_3v3_o),
        .calsel_o      (calsel_o),
        .calpwdn_o     (calpwdn_o)
    );

endmodule

`default_nettype wire

/* tio_id_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tio_id_ctrl #(
    parameter int          REQ_CREDITS   = 2,
    parameter logic [3:0]  VER_MAJOR     = 4'd0,
    parameter logic [3:0]  VER_MINOR     = 4'd6,
    parameter logic [7:0]  VER_REV       = 8'd0,
    parameter logic [15:0] FIRMWARE_DATE = 16'h0000
) (
    input  wire                       init_clk,
    input  wire                       rst_n_i,
    input  wire                       req_valid_i,
    input  wire turfio_pkg::reg_op_e  req_op_i,
    input  wire turfio_pkg::reg_sel_e req_addr_i,
    input  wire [31:0]                req_wdata_i,
    output logic                      credit_o,
    output logic                      resp_valid_o,
    output logic [31:0]               resp_rdata_o,
    input  wire [7:0]                 rx_count_i,
    input  wire [1:0]                 conf_i,
    input  wire                       tctrl_b_i,
    output logic                      hsk_local_o,
    output logic                      crate_en_o,
    output logic                      enable_crate_o,
    output logic                      enable_3v3_o,
    output logic                      calsel_o,
    output logic                      calpwdn_o
);
    import turfio_pkg::*;

    localparam int          PTR_W   = (REQ_CREDITS > 1) ? $clog2(REQ_CREDITS) : 1;
    localparam int          CNT_W   = $clog2(REQ_CREDITS + 1);
    localparam logic [31:0] DATEVER = {FIRMWARE_DATE, VER_MAJOR, VER_MINOR, VER_REV};

    // Request queue, one slot per credit
    reg_op_e               q_op    [REQ_CREDITS];
    reg_sel_e              q_addr  [REQ_CREDITS];
    logic [31:0]           q_wdata [REQ_CREDITS];
    logic [PTR_W-1:0]      wr_ptr_q;
    logic [PTR_W-1:0]      rd_ptr_q;
    logic [CNT_W-1:0]      q_count_q;
    logic                  take;
    logic                  take_q;
    // Execute stage
    logic                  s1_valid_q;
    reg_op_e               s1_op_q;
    reg_sel_e              s1_addr_q;
    logic [31:0]           s1_wdata_q;
    logic [CTRL_WIDTH-1:0] ctrl_q;
    logic [31:0]           status_word;
    logic [31:0]           rd_word;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(REQ_CREDITS - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Pop the head at most every other cycle
    assign take = (q_count_q != '0) && !take_q;

    always_ff @(posedge init_clk) begin
        if (req_valid_i) begin
            q_op[wr_ptr_q]    <= req_op_i;
            q_addr[wr_ptr_q]  <= req_addr_i;
            q_wdata[wr_ptr_q] <= req_wdata_i;
        end
        if (take) begin
            s1_op_q    <= q_op[rd_ptr_q];
            s1_addr_q  <= q_addr[rd_ptr_q];
            s1_wdata_q <= q_wdata[rd_ptr_q];
        end
        if (s1_valid_q) begin
            resp_rdata_o <= (s1_op_q == REG_WRITE) ? 32'd0 : rd_word;
        end
    end

    always_ff @(posedge init_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q     <= '0;
            rd_ptr_q     <= '0;
            q_count_q    <= '0;
            take_q       <= 1'b0;
            s1_valid_q   <= 1'b0;
            resp_valid_o <= 1'b0;
            credit_o     <= 1'b0;
            ctrl_q       <= '0;
        end else begin
            take_q     <= take;
            s1_valid_q <= take;
            // Response and credit leave together, two clocks after the pop
            resp_valid_o <= s1_valid_q;
            credit_o     <= s1_valid_q;
            if (req_valid_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (take) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            if (req_valid_i && !take) begin
                q_count_q <= q_count_q + 1'b1;
            end else if (!req_valid_i && take) begin
                q_count_q <= q_count_q - 1'b1;
            end
            // Writes land with the response, other addresses ignore them
            if (s1_valid_q && s1_op_q == REG_WRITE && s1_addr_q == REG_CONTROL) begin
                ctrl_q <= s1_wdata_q[CTRL_WIDTH-1:0];
            end
        end
    end

    ////////////////////////////////////////////////
    // Read words
    always_comb begin
        status_word = 32'd0;
        status_word[STAT_RXCOUNT_LSB +: 8] = rx_count_i;
        status_word[STAT_CONF_LSB +: 2]    = conf_i;
        status_word[STAT_TCTRL_B]          = tctrl_b_i;
    end

    always_comb begin
        case (s1_addr_q)
            REG_IDENT:   rd_word = TURFIO_IDENT;
            REG_DATEVER: rd_word = DATEVER;
            REG_CONTROL: rd_word = {{(32 - CTRL_WIDTH){1'b0}}, ctrl_q};
            REG_STATUS:  rd_word = status_word;
            default:     rd_word = 32'd0;
        endcase
    end

    assign hsk_local_o    = ctrl_q[CTRL_HSK_LOCAL];
    assign crate_en_o     = ctrl_q[CTRL_CRATE_EN];
    assign enable_crate_o = ctrl_q[CTRL_ENABLE_CRATE];
    assign enable_3v3_o   = ctrl_q[CTRL_EN_3V3];
    assign calsel_o       = ctrl_q[CTRL_CALSEL];
    assign calpwdn_o      = ctrl_q[CTRL_CALPWDN];

    // Requester spent a credit it did not hold
    a_no_overflow: assert property (@(posedge init_clk) disable iff (!rst_n_i)
        req_valid_i |-> (q_count_q != CNT_W'(REQ_CREDITS)));

    // Every response is one credit, tied to a pop two clocks back
    a_resp_credit: assert property (@(posedge init_clk) disable iff (!rst_n_i)
        (resp_valid_o || credit_o) |-> (resp_valid_o && credit_o && $past(take, 2)));

endmodule

`default_nettype wire

/* crate_uart_router.sv */
`timescale 1ns/1ps
`default_nettype none

module crate_uart_router #(
    parameter int BAUD_PERIOD = 160
) (
    input  wire        init_clk,
    input  wire        rst_n_i,
    input  wire        hsk_local_i,
    input  wire        crate_en_i,
    input  wire        dbg_rx_i,
    input  wire        turf_rx_i,
    input  wire        tctrl_b_i,
    input  wire        surf_retimed_i,
    input  wire        hsk_uart_rx_i,
    output logic       dbg_tx_o,
    output logic       turf_tx_o,
    output logic       surf_rx_o,
    output logic       hsk_uart_tx_o,
    output logic [7:0] rx_count_o
);
    import turfio_pkg::*;

    localparam int CNT_W = $clog2(BAUD_PERIOD);
    localparam int BIT_W = $clog2(UART_DATA_BITS);

    logic             crate_fwd;
    logic             crate_reply;
    logic             reply;
    logic             reply_q;
    uart_state_e      state_q;
    logic [CNT_W-1:0] cnt_q;
    logic [BIT_W-1:0] bit_q;
    logic             sample;

    //////////////////////////////////////////////////
    // Routing
    //////////////////////////////////////////////////

    // Local debug owns the bus, else TURF when it has the serial path
    // and an idle line when it has I2C instead
    assign crate_fwd = hsk_local_i ? dbg_rx_i : (tctrl_b_i ? 1'b1 : turf_rx_i);

    // Crate side silenced when disabled
    assign crate_reply = crate_en_i ? surf_retimed_i : 1'b1;

    // Wired-AND merge, either talker pulls low
    assign reply = crate_reply & hsk_uart_rx_i;

    // Housekeeping processor always listens
    assign hsk_uart_tx_o = crate_fwd;
    assign surf_rx_o     = crate_en_i ? crate_fwd : 1'b1;

    // Reply goes back to whoever drives the bus
    assign dbg_tx_o  = hsk_local_i ? reply : 1'b1;
    assign turf_tx_o = hsk_local_i ? 1'b1 : reply;

    //////////////////////////////////////////////////
    // Frame monitor
    //////////////////////////////////////////////////

    assign sample = (state_q != IDLE) && (cnt_q == '0);

    always_ff @(posedge init_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            cnt_q      <= '0;
            bit_q      <= '0;
            reply_q    <= 1'b1;
            rx_count_o <= 8'd0;
        end else begin
            reply_q <= reply;
            case (state_q)
                IDLE: begin
                    // Start edge, aim for the middle of the start bit
                    if (!reply && reply_q) begin
                        state_q <= START;
                        cnt_q   <= CNT_W'(BAUD_PERIOD / 2 - 1);
                    end
                end
                default: begin
                    if (sample) begin
                        cnt_q <= CNT_W'(BAUD_PERIOD - 1);
                        case (state_q)
                            START: begin
                                // High at mid start is a glitch
                                state_q <= reply ? IDLE : DATA;
                                bit_q   <= '0;
                            end
                            DATA: begin
                                bit_q <= bit_q + 1'b1;
                                if (bit_q == BIT_W'(UART_DATA_BITS - 1)) begin
                                    state_q <= STOP;
                                end
                            end
                            default: begin
                                // Good stop bit, count it, wraps at 8 bits
                                if (reply) begin
                                    rx_count_o <= rx_count_o + 8'd1;
                                end
                                state_q <= IDLE;
                            end
                        endcase
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
            endcase
        end
    end

    // Only one outside port carries the reply at a time
    a_one_reply_port: assert property (@(posedge init_clk) disable iff (!rst_n_i)
        !(!dbg_tx_o && !turf_tx_o));

endmodule

`default_nettype wire

/* uart_retime.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_retime #(
    parameter int BAUD_PERIOD  = 160,
    parameter int SAMPLE_POINT = 120
) (
    input  wire  init_clk,
    input  wire  rst_n_i,
    input  wire  line_i,
    output logic retimed_o
);
    import turfio_pkg::*;

    localparam int CNT_W = $clog2(BAUD_PERIOD);
    localparam int BIT_W = $clog2(UART_FRAME_BITS);

    uart_state_e      state_q;
    logic [CNT_W-1:0] cnt_q;
    logic [BIT_W-1:0] bit_q;
    logic             line_q;
    logic             sample;

    // Late sample point must land inside the bit
    if (SAMPLE_POINT >= BAUD_PERIOD) begin : g_bad_sample_point
        $error("uart_retime: SAMPLE_POINT must be below BAUD_PERIOD");
    end

    // Bit timer expired, sample this cycle
    assign sample = (state_q != IDLE) && (cnt_q == '0);

    always_ff @(posedge init_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            cnt_q     <= '0;
            bit_q     <= '0;
            line_q    <= 1'b1;
            retimed_o <= 1'b1;
        end else begin
            line_q <= line_i;
            if (state_q == IDLE) begin
                // Let go of the output once the line is back up
                if (line_q) begin
                    retimed_o <= 1'b1;
                end
                // Falling edge opens a frame
                if (!line_i && line_q) begin
                    state_q <= START;
                    cnt_q   <= CNT_W'(SAMPLE_POINT - 1);
                    bit_q   <= '0;
                end
            end else if (sample) begin
                // Clean level until the next sample
                retimed_o <= line_i;
                cnt_q     <= CNT_W'(BAUD_PERIOD - 1);
                bit_q     <= bit_q + 1'b1;
                if (bit_q == BIT_W'(UART_FRAME_BITS - 1)) begin
                    state_q <= IDLE;
                end else if (bit_q == BIT_W'(UART_DATA_BITS)) begin
                    state_q <= STOP;
                end else begin
                    state_q <= DATA;
                end
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // Output idles high once the line has been up for two clocks
    a_idle_high: assert property (@(posedge init_clk) disable iff (!rst_n_i)
        (state_q == IDLE) && line_q && $past(line_q) |-> retimed_o);

endmodule

`default_nettype wire

/* turfio_pkg.sv */
`default_nettype none

package turfio_pkg;

    // Register request opcode
    typedef enum logic {
        REG_READ  = 1'b0,
        REG_WRITE = 1'b1
    } reg_op_e;

    // Register word addresses, anything else reads zero
    typedef enum logic [3:0] {
        REG_IDENT   = 4'd0,
        REG_DATEVER = 4'd1,
        REG_CONTROL = 4'd2,
        REG_STATUS  = 4'd3
    } reg_sel_e;

    // Serial frame walk, shared by retimer and frame monitor
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } uart_state_e;

    // ASCII "TFIO"
    localparam logic [31:0] TURFIO_IDENT = 32'h5446_494F;

    // 8N1 framing
    localparam int UART_DATA_BITS  = 8;
    localparam int UART_FRAME_BITS = 10;

    ////////////////////////////////////////////////
    // Control register bits
    localparam int CTRL_HSK_LOCAL    = 0;
    localparam int CTRL_CRATE_EN     = 1;
    localparam int CTRL_ENABLE_CRATE = 2;
    localparam int CTRL_EN_3V3       = 3;
    localparam int CTRL_CALSEL       = 4;
    localparam int CTRL_CALPWDN      = 5;
    localparam int CTRL_WIDTH        = 6;

    // Status word fields
    localparam int STAT_RXCOUNT_LSB = 0;
    localparam int STAT_CONF_LSB    = 8;
    localparam int STAT_TCTRL_B     = 10;

endpackage

`default_nettype wire
